// ==== compile.f ====
+incdir+verilog
verilog/mult_op_pkg.sv
verilog/mult_data_pkg.sv
verilog/mult_decode.sv
verilog/mult_wide.sv
verilog/mult_simd.sv
verilog/mult_writeback.sv
verilog/mult_unit.sv
dv/mult_unit_assert.sv
dv/mult_unit_tb.sv

// ==== Bender.yml ====
package:
  name: mult_unit

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/mult_op_pkg.sv
      - verilog/mult_data_pkg.sv
      - verilog/mult_decode.sv
      - verilog/mult_wide.sv
      - verilog/mult_simd.sv
      - verilog/mult_writeback.sv
      - verilog/mult_unit.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - dv/mult_unit_assert.sv
      - dv/mult_unit_tb.sv

// ==== dv/mult_unit_tb.sv ====
// Multiply unit testbench
// Drives random scalar, packed and dot-product operations with idle
// and no-op cycles, predicts each result from the operation rules
// and checks result timing, tags and values against the DUT

`default_nettype none

module mult_unit_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import mult_op_pkg::*;
  import mult_data_pkg::*;

  localparam int          NUM_OPS       = 400;
  localparam int          DRAIN_TIMEOUT = 20;
  localparam int unsigned SEED          = 32'h33cf1df6;

  logic     clk_i = 1'b0;
  logic     rst_ni;
  logic     valid_i;
  mult_op_e op_i;
  tag_t     tag_i;
  word_t    operand_a_i;
  word_t    operand_b_i;
  word_t    operand_c_i;
  logic     valid_o;
  tag_t     tag_o;
  word_t    result_o;

  // Expected results in issue order
  tag_t     exp_tag_q [$];
  word_t    exp_res_q [$];
  tag_t     exp_tag;
  word_t    exp_res;
  logic     expect_valid = 1'b0;

  int          mismatch_count = 0;
  int          other_errors   = 0;
  int          accepted_count = 0;
  int          result_count   = 0;
  int          total_errors;
  int          wait_cycles;

  always #4 clk_i = ~clk_i;

  mult_unit uut (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .valid_i     (valid_i),
    .op_i        (op_i),
    .tag_i       (tag_i),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .operand_c_i (operand_c_i),
    .valid_o     (valid_o),
    .tag_o       (tag_o),
    .result_o    (result_o)
  );

  // ------------------------------------------------------------
  // Reference model
  // ------------------------------------------------------------
  function automatic word_t model_result(input mult_op_e op, input word_t a,
                                         input word_t b, input word_t c);
    longint a_s;
    longint b_s;
    longint a_u;
    longint b_u;
    longint prod;
    int     lane_p [4];
    int     acc;
    a_s = longint'($signed(a));
    b_s = longint'($signed(b));
    a_u = {32'b0, a};
    b_u = {32'b0, b};
    acc = c;
    for (int k = 0; k < 4; k++) begin
      if (op == OP_SMUL8) begin
        lane_p[k] = int'($signed(a[8*k +: 8])) * int'($signed(b[8*k +: 8]));
      end else begin
        lane_p[k] = int'(a[8*k +: 8]) * int'(b[8*k +: 8]);
      end
      // Dot product uses unsigned bytes of A against signed bytes of B
      acc = acc + int'(a[8*k +: 8]) * int'($signed(b[8*k +: 8]));
    end
    case (op)
      OP_MUL:             prod = a_u * b_u;
      OP_MULH:            prod = a_s * b_s;
      OP_MULHU:           prod = a_u * b_u;
      OP_MULHSU:          prod = a_s * b_u;
      default:            prod = 0;
    endcase
    case (op)
      OP_MUL:                       model_result = prod[31:0];
      OP_MULH, OP_MULHU, OP_MULHSU: model_result = prod[63:32];
      OP_SMUL8, OP_UMUL8:           model_result = {lane_p[1][15:0], lane_p[0][15:0]};
      OP_SMAQA:                     model_result = acc;
      default:                      model_result = '0;
    endcase
  endfunction

  // Random word with a bias toward corner values
  function automatic word_t pick_operand();
    int unsigned sel;
    sel = $urandom_range(0, 9);
    case (sel)
      0:       pick_operand = 32'h0000_0000;
      1:       pick_operand = 32'hffff_ffff;
      2:       pick_operand = 32'h8000_0000;
      3:       pick_operand = 32'h7f80_ff01;
      default: pick_operand = $urandom();
    endcase
  endfunction

  task automatic drive_random_op();
    op_i        = mult_op_e'($urandom_range(0, 7));
    valid_i     = ($urandom_range(0, 3) != 0);
    tag_i       = tag_t'($urandom_range(0, 7));
    operand_a_i = pick_operand();
    operand_b_i = pick_operand();
    operand_c_i = pick_operand();
  endtask

  // ------------------------------------------------------------
  // Scoreboard, sampled mid-cycle
  // ------------------------------------------------------------
  always @(negedge clk_i) begin
    assert (valid_o === expect_valid) else begin
      $display("MISMATCH at %0t: valid_o is %b, expected %b", $time, valid_o, expect_valid);
      mismatch_count++;
    end
    if (valid_o === 1'b1) begin
      result_count++;
      if (exp_tag_q.size() == 0) begin
        $display("ERROR at %0t: a result came back with no operation outstanding", $time);
        other_errors++;
      end else begin
        exp_tag = exp_tag_q.pop_front();
        exp_res = exp_res_q.pop_front();
        assert (tag_o === exp_tag) else begin
          $display("MISMATCH at %0t: tag_o %0d, expected %0d", $time, tag_o, exp_tag);
          mismatch_count++;
        end
        assert (result_o === exp_res) else begin
          $display("MISMATCH at %0t: result_o %h, expected %h", $time, result_o, exp_res);
          mismatch_count++;
        end
      end
    end
    // Inputs seen now are captured at the next rising edge
    expect_valid = rst_ni && valid_i && (op_i != OP_NONE);
    if (expect_valid) begin
      accepted_count++;
      exp_tag_q.push_back(tag_i);
      exp_res_q.push_back(model_result(op_i, operand_a_i, operand_b_i, operand_c_i));
    end
  end

  // ------------------------------------------------------------
  // Stimulus and end of run
  // ------------------------------------------------------------
  initial begin
    void'($urandom(SEED));
    rst_ni      = 1'b0;
    valid_i     = 1'b0;
    op_i        = OP_NONE;
    tag_i       = '0;
    operand_a_i = '0;
    operand_b_i = '0;
    operand_c_i = '0;
    repeat (4) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    for (int i = 0; i < NUM_OPS; i++) begin
      @(posedge clk_i);
      #1;
      drive_random_op();
    end
    @(posedge clk_i);
    #1;
    valid_i = 1'b0;
    op_i    = OP_NONE;

    wait_cycles = 0;
    while (exp_tag_q.size() != 0 && wait_cycles < DRAIN_TIMEOUT) begin
      @(posedge clk_i);
      wait_cycles++;
    end
    if (exp_tag_q.size() != 0) begin
      $display("ERROR: %0d results never came back before the drain timeout",
               exp_tag_q.size());
      other_errors++;
    end
    // A few idle cycles to catch stray results
    repeat (3) @(posedge clk_i);

    assert (accepted_count == result_count) else begin
      $display("ERROR: %0d operations were accepted but %0d results came back",
               accepted_count, result_count);
      other_errors++;
    end

    total_errors = mismatch_count + other_errors + uut.u_assert.fail_count;
    $display("Done: %0d accepted, %0d mismatches, %0d other errors, %0d assertion failures",
             accepted_count, mismatch_count, other_errors, uut.u_assert.fail_count);
    if (total_errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== dv/mult_unit_assert.sv ====
// Multiply unit handshake assertions
// Checks result timing, tag return and the reset state of valid_o

`default_nettype none

module mult_unit_assert (
  input logic                  clk_i,
  input logic                  rst_ni,
  input logic                  valid_i,
  input mult_op_pkg::mult_op_e op_i,
  input mult_data_pkg::tag_t   tag_i,
  input logic                  valid_o,
  input mult_data_pkg::tag_t   tag_o
);
  timeunit 1ns;
  timeprecision 100ps;
  import mult_op_pkg::*;

  int   fail_count = 0;
  logic accepted;

  assign accepted = valid_i && (op_i != OP_NONE);

  // A result follows each accepted operation one cycle later, and only then
  a_valid_after_accept: assert property (@(posedge clk_i) disable iff (!rst_ni)
    accepted |=> valid_o)
  else begin
    $error("valid_o did not rise one cycle after an accepted operation");
    fail_count++;
  end

  a_no_valid_when_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !accepted |=> !valid_o)
  else begin
    $error("valid_o rose without an accepted operation one cycle earlier");
    fail_count++;
  end

  a_tag_returned: assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_o |-> (tag_o == $past(tag_i)))
  else begin
    $error("tag_o does not match the tag of the previous cycle");
    fail_count++;
  end

  a_idle_in_reset: assert property (@(posedge clk_i) !rst_ni |-> !valid_o)
  else begin
    $error("valid_o was high while reset was asserted");
    fail_count++;
  end

endmodule

bind mult_unit mult_unit_assert u_assert (
  .clk_i   (clk_i),
  .rst_ni  (rst_ni),
  .valid_i (valid_i),
  .op_i    (op_i),
  .tag_i   (tag_i),
  .valid_o (valid_o),
  .tag_o   (tag_o)
);

`default_nettype wire

// ==== verilog/mult_unit.sv ====
// Pipelined integer multiply unit
// Accepts one scalar, packed or dot-product operation per cycle and
// returns its result with the matching tag one cycle later

`default_nettype none

module mult_unit (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  valid_i,
  input  mult_op_pkg::mult_op_e op_i,
  input  mult_data_pkg::tag_t   tag_i,
  input  mult_data_pkg::word_t  operand_a_i,
  input  mult_data_pkg::word_t  operand_b_i,
  input  mult_data_pkg::word_t  operand_c_i,
  output logic                  valid_o,
  output mult_data_pkg::tag_t   tag_o,
  output mult_data_pkg::word_t  result_o
);
  import mult_data_pkg::*;
  import mult_op_pkg::*;

  sign_mode_e sign_a;
  sign_mode_e sign_b;
  logic       accept;
  dword_t     product;
  word_t      packed_word;
  word_t      dot_word;

  // ------------------------------------------------------------
  // Decode
  // ------------------------------------------------------------
  mult_decode u_decode (
    .op_i     (op_i),
    .valid_i  (valid_i),
    .sign_a_o (sign_a),
    .sign_b_o (sign_b),
    .accept_o (accept)
  );

  // ------------------------------------------------------------
  // Datapaths
  // ------------------------------------------------------------
  mult_wide u_wide (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .sign_a_i    (sign_a),
    .sign_b_i    (sign_b),
    .product_o   (product)
  );

  mult_simd u_simd (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .operand_c_i (operand_c_i),
    .sign_a_i    (sign_a),
    .sign_b_i    (sign_b),
    .packed_o    (packed_word),
    .dot_o       (dot_word)
  );

  // Output stage
  mult_writeback u_writeback (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .accept_i  (accept),
    .op_i      (op_i),
    .tag_i     (tag_i),
    .product_i (product),
    .packed_i  (packed_word),
    .dot_i     (dot_word),
    .valid_o   (valid_o),
    .tag_o     (tag_o),
    .result_o  (result_o)
  );

endmodule

`default_nettype wire

// ==== verilog/mult_writeback.sv ====
// Multiply writeback stage
// Holds the accept flag, tag and opcode for one cycle alongside the
// registered products, then picks the result word for the opcode

`default_nettype none

`include "mult_consts.svh"

module mult_writeback (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  accept_i,
  input  mult_op_pkg::mult_op_e op_i,
  input  mult_data_pkg::tag_t   tag_i,
  input  mult_data_pkg::dword_t product_i,
  input  mult_data_pkg::word_t  packed_i,
  input  mult_data_pkg::word_t  dot_i,
  output logic                  valid_o,
  output mult_data_pkg::tag_t   tag_o,
  output mult_data_pkg::word_t  result_o
);
  import mult_data_pkg::*;
  import mult_op_pkg::*;

  logic     valid_q;
  tag_t     tag_q;
  mult_op_e op_q;

  // ------------------------------------------------------------
  // Control pipeline register
  // ------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      tag_q   <= '0;
      op_q    <= OP_NONE;
    end else begin
      valid_q <= accept_i;
      tag_q   <= tag_i;
      op_q    <= op_i;
    end
  end

  assign valid_o = valid_q;
  assign tag_o   = tag_q;

  // ------------------------------------------------------------
  // Result select
  // ------------------------------------------------------------
  always_comb begin
    case (op_q)
      OP_MULH, OP_MULHU, OP_MULHSU: result_o = product_i[2*`MULT_XLEN-1:`MULT_XLEN];
      OP_MUL:                       result_o = product_i[`MULT_XLEN-1:0];
      OP_SMUL8, OP_UMUL8:           result_o = packed_i;
      OP_SMAQA:                     result_o = dot_i;
      // No result is signalled for a no-op
      default:                      result_o = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== verilog/mult_simd.sv ====
// Packed byte multiplier
// Four byte-lane multipliers feed the packed product of lanes 1
// and 0 and a dot product of all lanes plus operand C, both
// registered for one cycle of latency

`default_nettype none

`include "mult_consts.svh"

module mult_simd (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  mult_data_pkg::word_t    operand_a_i,
  input  mult_data_pkg::word_t    operand_b_i,
  input  mult_data_pkg::word_t    operand_c_i,
  input  mult_op_pkg::sign_mode_e sign_a_i,
  input  mult_op_pkg::sign_mode_e sign_b_i,
  output mult_data_pkg::word_t    packed_o,
  output mult_data_pkg::word_t    dot_o
);
  import mult_data_pkg::*;
  import mult_op_pkg::*;

  logic       a_signed;
  logic       b_signed;
  lane_prod_t lane_prod [`MULT_LANES];
  word_t      lane_ext  [`MULT_LANES];
  word_t      packed_d;
  word_t      dot_d;

  assign a_signed = (sign_a_i == SIGN_SIGNED);
  assign b_signed = (sign_b_i == SIGN_SIGNED);

  // ------------------------------------------------------------
  // Byte lanes
  // ------------------------------------------------------------
  for (genvar k = 0; k < `MULT_LANES; k++) begin : g_lane
    logic signed [`MULT_LANE_W:0]     a_ext;
    logic signed [`MULT_LANE_W:0]     b_ext;
    logic signed [2*`MULT_LANE_W+1:0] full_prod;

    assign a_ext = {operand_a_i[k*`MULT_LANE_W+`MULT_LANE_W-1] & a_signed,
                    operand_a_i[k*`MULT_LANE_W +: `MULT_LANE_W]};
    assign b_ext = {operand_b_i[k*`MULT_LANE_W+`MULT_LANE_W-1] & b_signed,
                    operand_b_i[k*`MULT_LANE_W +: `MULT_LANE_W]};

    assign full_prod    = a_ext * b_ext;
    assign lane_prod[k] = full_prod[2*`MULT_LANE_W-1:0];

    // Lane products are signed 16-bit values when accumulated
    assign lane_ext[k] = {{(`MULT_XLEN-2*`MULT_LANE_W){lane_prod[k][2*`MULT_LANE_W-1]}},
                          lane_prod[k]};
  end

  // Low two lanes side by side
  assign packed_d = {lane_prod[1], lane_prod[0]};

  // Sum of all lanes plus accumulator, wraps at 32 bits
  always_comb begin
    dot_d = operand_c_i;
    for (int k = 0; k < `MULT_LANES; k++) begin
      dot_d = dot_d + lane_ext[k];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      packed_o <= '0;
      dot_o    <= '0;
    end else begin
      packed_o <= packed_d;
      dot_o    <= dot_d;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/mult_wide.sv ====
// Scalar multiplier
// Extends both words by one bit according to their sign mode,
// forms the 33 x 33 signed product and registers its low 64 bits

`default_nettype none

`include "mult_consts.svh"

module mult_wide (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  mult_data_pkg::word_t    operand_a_i,
  input  mult_data_pkg::word_t    operand_b_i,
  input  mult_op_pkg::sign_mode_e sign_a_i,
  input  mult_op_pkg::sign_mode_e sign_b_i,
  output mult_data_pkg::dword_t   product_o
);
  import mult_data_pkg::*;
  import mult_op_pkg::*;

  logic signed [`MULT_XLEN:0]       a_ext;
  logic signed [`MULT_XLEN:0]       b_ext;
  logic signed [2*`MULT_XLEN+1:0]   full_prod;
  dword_t                           product_d;

  // Top bit replicated only for signed operands
  assign a_ext = {operand_a_i[`MULT_XLEN-1] & (sign_a_i == SIGN_SIGNED), operand_a_i};
  assign b_ext = {operand_b_i[`MULT_XLEN-1] & (sign_b_i == SIGN_SIGNED), operand_b_i};

  assign full_prod = a_ext * b_ext;
  assign product_d = full_prod[2*`MULT_XLEN-1:0];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      product_o <= '0;
    end else begin
      product_o <= product_d;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/mult_decode.sv ====
// Multiply operation decoder
// Derives the sign mode of each operand from the opcode and flags
// an operation as accepted when it is valid and not a no-op

`default_nettype none

module mult_decode (
  input  mult_op_pkg::mult_op_e   op_i,
  input  logic                    valid_i,
  output mult_op_pkg::sign_mode_e sign_a_o,
  output mult_op_pkg::sign_mode_e sign_b_o,
  output logic                    accept_o
);
  import mult_op_pkg::*;

  // Only real operations enter the pipeline
  assign accept_o = valid_i && (op_i inside {OP_MUL, OP_MULH, OP_MULHU, OP_MULHSU,
                                             OP_SMUL8, OP_UMUL8, OP_SMAQA});

  // ------------------------------------------------------------
  // Operand sign select
  // ------------------------------------------------------------
  always_comb begin
    sign_a_o = SIGN_UNSIGNED;
    sign_b_o = SIGN_UNSIGNED;
    case (op_i)
      OP_MULH, OP_SMUL8: begin
        sign_a_o = SIGN_SIGNED;
        sign_b_o = SIGN_SIGNED;
      end
      OP_MULHSU: begin
        sign_a_o = SIGN_SIGNED;
      end
      // Dot product takes unsigned bytes of A, signed bytes of B
      OP_SMAQA: begin
        sign_b_o = SIGN_SIGNED;
      end
      default: begin
        sign_a_o = SIGN_UNSIGNED;
        sign_b_o = SIGN_UNSIGNED;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== verilog/mult_data_pkg.sv ====
// Multiply unit data package
// Word, full product, lane product and tag types of the datapath

`default_nettype none

`include "mult_consts.svh"

package mult_data_pkg;

  // One register-file word
  typedef logic [`MULT_XLEN-1:0] word_t;

  // Full scalar product, high and low halves
  typedef logic [2*`MULT_XLEN-1:0] dword_t;

  // Product of one byte lane
  typedef logic [2*`MULT_LANE_W-1:0] lane_prod_t;

  // Transaction tag carried alongside each operation
  typedef logic [`MULT_TAG_W-1:0] tag_t;

endpackage

`default_nettype wire

// ==== verilog/mult_op_pkg.sv ====
// Multiply unit operation package
// Opcode encoding seen at the unit boundary and the per-operand
// sign mode produced by the decoder

`default_nettype none

package mult_op_pkg;

  // Operation selector, OP_NONE produces no result
  typedef enum logic [2:0] {
    OP_NONE   = 3'd0,
    OP_MUL    = 3'd1,
    OP_MULH   = 3'd2,
    OP_MULHU  = 3'd3,
    OP_MULHSU = 3'd4,
    OP_SMUL8  = 3'd5,
    OP_UMUL8  = 3'd6,
    OP_SMAQA  = 3'd7
  } mult_op_e;

  // How an operand is extended before multiplication
  typedef enum logic {
    SIGN_UNSIGNED = 1'b0,
    SIGN_SIGNED   = 1'b1
  } sign_mode_e;

endpackage

`default_nettype wire

// ==== verilog/mult_consts.svh ====
// Multiply unit constants
// Word width, packed lane geometry and transaction tag width shared by
// the type package and the datapath modules

`ifndef MULT_CONSTS_SVH
`define MULT_CONSTS_SVH

// Operand and result width
`define MULT_XLEN 32

// Packed SIMD lane width and number of lanes in a word
`define MULT_LANE_W 8
`define MULT_LANES 4

// Transaction tag width
`define MULT_TAG_W 3

`endif
